// File: design/boot_rom.sv
// Boot ROM
// Small read-only word table with a registered response
`timescale 1ns/1ps

module boot_rom (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                req_i,
  input  msys_pkg::bus_req_t  bus_i,
  output msys_pkg::bus_resp_t resp_o
);

  import msys_pkg::*;

  logic [OffsetWidth-ByteOffsetWidth-1:0] idx;
  bus_resp_t                              resp_d;
  bus_resp_t                              resp_q;

  assign idx = bus_i.addr.split.offset[OffsetWidth-1:ByteOffsetWidth];

  always_comb begin
    resp_d.err   = 1'b0;
    resp_d.rdata = '0;   // Past the table end
    if (bus_i.we) begin
      resp_d.err   = 1'b1;
      resp_d.rdata = ErrData;
    end else if (idx < BootNumWords) begin
      resp_d.rdata = boot_word(int'(idx));
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      resp_q <= '0;
    end else if (req_i) begin
      resp_q <= resp_d;
    end
  end

  assign resp_o = resp_q;

endmodule : boot_rom

// File: design/bus_router.sv
// Host bus router
// Decodes the host address, strobes one local target or runs the external
// four-phase handshake, then holds the response until the host releases req
`timescale 1ns/1ps

module bus_router (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Host port
  input  logic                req_i,
  input  msys_pkg::bus_req_t  host_req_i,
  output logic                ack_o,
  output msys_pkg::bus_resp_t host_resp_o,
  output logic                busy_o,
  // External master port
  output logic                ext_req_o,
  output msys_pkg::bus_req_t  ext_bus_o,
  input  logic                ext_ack_i,
  input  msys_pkg::bus_resp_t ext_resp_i,
  input  logic                timeout_i,
  // Local targets
  output logic                mem_req_o,
  output logic                rom_req_o,
  output logic                reg_req_o,
  output msys_pkg::bus_req_t  loc_bus_o,
  input  msys_pkg::bus_resp_t mem_resp_i,
  input  msys_pkg::bus_resp_t rom_resp_i,
  input  msys_pkg::bus_resp_t reg_resp_i
);

  import msys_pkg::*;

  typedef enum logic [2:0] {
    Idle,
    Access,
    ExtWait,
    ExtRelease,
    Respond
  } state_e;

  state_e    state_q;
  bus_req_t  req_q;
  target_e   target_q;
  target_e   req_target;
  bus_resp_t resp_q;
  bus_resp_t loc_resp;
  logic      mem_req_q;
  logic      rom_req_q;
  logic      reg_req_q;
  logic      strobe_q;

  // Address map, anything unmatched goes out of the system
  function automatic target_e decode(addr_u addr);
    if (addr.split.region == CtrlBaseAddr[AddrWidth-1 -: RegionWidth]) begin
      return CtrlRegs;
    end else if (addr.split.region == BootBaseAddr[AddrWidth-1 -: RegionWidth]) begin
      return BootRom;
    end else if (addr.split.region == L2BaseAddr[AddrWidth-1 -: RegionWidth] &&
                 addr.split.offset < OffsetWidth'(L2NumWords * BeWidth)) begin
      return L2Mem;
    end
    return External;
  endfunction

  assign req_target = decode(host_req_i.addr);
  assign strobe_q   = mem_req_q | rom_req_q | reg_req_q;

  always_comb begin
    case (target_q)
      L2Mem:   loc_resp = mem_resp_i;
      BootRom: loc_resp = rom_resp_i;
      default: loc_resp = reg_resp_i;
    endcase
  end

  // Control path
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= Idle;
      mem_req_q <= 1'b0;
      rom_req_q <= 1'b0;
      reg_req_q <= 1'b0;
    end else begin
      mem_req_q <= 1'b0; // Strobes last a single cycle
      rom_req_q <= 1'b0;
      reg_req_q <= 1'b0;
      case (state_q)
        Idle: begin
          if (req_i) begin
            state_q   <= (req_target == External) ? ExtWait : Access;
            mem_req_q <= (req_target == L2Mem);
            rom_req_q <= (req_target == BootRom);
            reg_req_q <= (req_target == CtrlRegs);
          end
        end
        Access: begin
          if (!strobe_q) state_q <= Respond; // Target answered this cycle
        end
        ExtWait: begin
          if (ext_ack_i || timeout_i) state_q <= ExtRelease;
        end
        ExtRelease: begin
          if (!ext_ack_i) state_q <= Respond;
        end
        Respond: begin
          if (!req_i) state_q <= Idle;
        end
        default: state_q <= Idle;
      endcase
    end
  end

  // Request and response payload
  always_ff @(posedge clk_i) begin
    if (state_q == Idle && req_i) begin
      req_q    <= host_req_i;
      target_q <= req_target;
    end
    if (state_q == Access && !strobe_q) resp_q <= loc_resp;
    if (state_q == ExtWait) begin
      if (ext_ack_i) begin
        resp_q <= ext_resp_i;
      end else if (timeout_i) begin
        resp_q.rdata <= ErrData;
        resp_q.err   <= 1'b1;
      end
    end
  end

  assign ack_o       = (state_q == Respond);
  assign busy_o      = (state_q != Idle);
  assign host_resp_o = resp_q;
  assign ext_req_o   = (state_q == ExtWait);
  assign ext_bus_o   = req_q;   // Raw address passes through unchanged
  assign loc_bus_o   = req_q;
  assign mem_req_o   = mem_req_q;
  assign rom_req_o   = rom_req_q;
  assign reg_req_o   = reg_req_q;

endmodule : bus_router

// File: design/ctrl_regs.sv
// Control register block
// Core wake-up pulses, end-of-computation register and read-only constants
`timescale 1ns/1ps

module ctrl_regs (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          req_i,
  input  msys_pkg::bus_req_t            bus_i,
  output msys_pkg::bus_resp_t           resp_o,
  output logic [msys_pkg::NumCores-1:0] wake_up_o,
  output msys_pkg::data_t               eoc_o,
  output logic                          eoc_valid_o
);

  import msys_pkg::*;

  logic [NumCores-1:0]    wake_up_q;
  data_t                  eoc_q;
  bus_resp_t              resp_d;
  bus_resp_t              resp_q;
  logic [OffsetWidth-1:0] offset;

  assign offset = bus_i.addr.split.offset;

  // Read data and error decode
  always_comb begin
    resp_d.rdata = '0;
    resp_d.err   = 1'b0;
    case (offset)
      CtrlWakeOffset: ;                        // Write-only pulse, reads zero
      CtrlEocOffset:  resp_d.rdata = eoc_q;
      CtrlTcdmOffset: begin
        resp_d.rdata = TcdmStartAddr;
        resp_d.err   = bus_i.we;
      end
      CtrlCoresOffset: begin
        resp_d.rdata = data_t'(NumCores);
        resp_d.err   = bus_i.we;
      end
      default: resp_d.err = 1'b1;
    endcase
    if (resp_d.err) resp_d.rdata = ErrData;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wake_up_q <= '0;
      eoc_q     <= '0;
      resp_q    <= '0;
    end else begin
      wake_up_q <= '0;                         // Pulse lasts one cycle
      if (req_i) begin
        resp_q <= resp_d;
        if (bus_i.we && offset == CtrlWakeOffset && bus_i.be[0]) begin
          wake_up_q <= bus_i.wdata[NumCores-1:0];
        end
        if (bus_i.we && offset == CtrlEocOffset) begin
          eoc_q <= apply_be(eoc_q, bus_i.wdata, bus_i.be);
        end
      end
    end
  end

  assign resp_o      = resp_q;
  assign wake_up_o   = wake_up_q;
  assign eoc_o       = eoc_q;
  assign eoc_valid_o = eoc_q[0];

endmodule : ctrl_regs

// File: design/ext_timeout_timer.sv
// External access timer
// Counts cycles spent waiting on the external port and flags a timeout
`timescale 1ns/1ps

module ext_timeout_timer (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic run_i,
  output logic timeout_o
);

  import msys_pkg::*;

  logic [TimerWidth-1:0] count_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else if (!run_i) begin
      count_q <= '0; // Idle between accesses
    end else if (count_q != TimerWidth'(ExtTimeoutCycles)) begin
      count_q <= count_q + 1'b1;
    end
  end

  // Saturates until run_i drops
  assign timeout_o = (count_q == TimerWidth'(ExtTimeoutCycles));

endmodule : ext_timeout_timer

// File: design/l2_mem.sv
// L2 scratch memory
// Single-port word array with byte enables and a registered response
`timescale 1ns/1ps

module l2_mem (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                req_i,
  input  msys_pkg::bus_req_t  bus_i,
  output msys_pkg::bus_resp_t resp_o
);

  import msys_pkg::*;

  data_t                 mem_q [L2NumWords];
  logic [L2IdxWidth-1:0] idx;
  data_t                 rdata_q;

  assign idx = bus_i.addr.split.offset[ByteOffsetWidth +: L2IdxWidth];

  // Storage
  always_ff @(posedge clk_i) begin
    if (req_i && bus_i.we) begin
      mem_q[idx] <= apply_be(mem_q[idx], bus_i.wdata, bus_i.be);
    end
  end

  // Old word is returned on writes as well
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rdata_q <= '0;
    end else if (req_i) begin
      rdata_q <= mem_q[idx];
    end
  end

  assign resp_o.rdata = rdata_q;
  assign resp_o.err   = 1'b0;   // L2 never faults

endmodule : l2_mem

// File: design/msys_pkg.sv
// System shell package
// Address map, bus widths, request/response structs and the boot ROM contents

package msys_pkg;

  localparam int unsigned AddrWidth   = 32;
  localparam int unsigned DataWidth   = 32;
  localparam int unsigned BeWidth     = DataWidth / 8;
  localparam int unsigned RegionWidth = 16;
  localparam int unsigned OffsetWidth = AddrWidth - RegionWidth;
  localparam int unsigned ByteOffsetWidth = $clog2(BeWidth);

  localparam int unsigned NumCores = 4;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [BeWidth-1:0]   be_t;

  // Address map, every window is one 64 KiB region except L2
  localparam addr_t       L2BaseAddr   = 32'h8000_0000;
  localparam int unsigned L2NumWords   = 256;          // 1 KiB
  localparam int unsigned L2IdxWidth   = $clog2(L2NumWords);
  localparam addr_t       CtrlBaseAddr = 32'h4000_0000;
  localparam addr_t       BootBaseAddr = 32'hA000_0000;
  localparam int unsigned BootNumWords = 16;

  localparam int unsigned ExtTimeoutCycles = 16;
  localparam int unsigned TimerWidth       = $clog2(ExtTimeoutCycles + 1);

  localparam data_t ErrData       = 32'hBADC_AB1E;
  localparam addr_t TcdmStartAddr = 32'h0000_0000;

  // Control register offsets
  localparam logic [OffsetWidth-1:0] CtrlWakeOffset  = 16'h0000;
  localparam logic [OffsetWidth-1:0] CtrlEocOffset   = 16'h0004;
  localparam logic [OffsetWidth-1:0] CtrlTcdmOffset  = 16'h0008;
  localparam logic [OffsetWidth-1:0] CtrlCoresOffset = 16'h000C;

  typedef struct packed {
    logic [RegionWidth-1:0] region; // Compared against the map
    logic [OffsetWidth-1:0] offset; // Used inside local targets
  } addr_split_t;

  // Same address word, raw for the external port or split for decoding
  typedef union packed {
    addr_t       raw;
    addr_split_t split;
  } addr_u;

  typedef struct packed {
    addr_u addr;
    data_t wdata;
    be_t   be;
    logic  we;
  } bus_req_t;

  typedef struct packed {
    data_t rdata;
    logic  err;
  } bus_resp_t;

  typedef enum logic [1:0] {
    CtrlRegs,
    L2Mem,
    BootRom,
    External
  } target_e;

  // Boot ROM word i
  function automatic data_t boot_word(int unsigned i);
    return 32'hB007_0000 + data_t'(i);
  endfunction

  // Byte-enable merge of new data over an old word
  function automatic data_t apply_be(data_t old_word, data_t new_word, be_t be);
    data_t merged;
    merged = old_word;
    for (int b = 0; b < BeWidth; b++) begin
      if (be[b]) merged[8*b +: 8] = new_word[8*b +: 8];
    end
    return merged;
  endfunction

endpackage : msys_pkg

// File: design/msys_top.sv
// System top level
// Joins the router, timeout timer, L2, boot ROM, control registers and
// the external master port
`timescale 1ns/1ps

module msys_top (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  // Host port
  input  logic                          req_i,
  input  msys_pkg::bus_req_t            host_req_i,
  output logic                          ack_o,
  output msys_pkg::bus_resp_t           host_resp_o,
  output logic                          busy_o,
  // External master port
  output logic                          ext_req_o,
  output msys_pkg::bus_req_t            ext_bus_o,
  input  logic                          ext_ack_i,
  input  msys_pkg::bus_resp_t           ext_resp_i,
  // System status
  output logic [msys_pkg::NumCores-1:0] wake_up_o,
  output msys_pkg::data_t               eoc_o,
  output logic                          eoc_valid_o
);

  import msys_pkg::*;

  logic      timeout;
  logic      mem_req;
  logic      rom_req;
  logic      reg_req;
  bus_req_t  loc_bus;
  bus_resp_t mem_resp;
  bus_resp_t rom_resp;
  bus_resp_t reg_resp;

  bus_router bus_router_inst (
    .clk_i      (clk_i      ),
    .rst_n_i    (rst_n_i    ),
    .req_i      (req_i      ),
    .host_req_i (host_req_i ),
    .ack_o      (ack_o      ),
    .host_resp_o(host_resp_o),
    .busy_o     (busy_o     ),
    .ext_req_o  (ext_req_o  ),
    .ext_bus_o  (ext_bus_o  ),
    .ext_ack_i  (ext_ack_i  ),
    .ext_resp_i (ext_resp_i ),
    .timeout_i  (timeout    ),
    .mem_req_o  (mem_req    ),
    .rom_req_o  (rom_req    ),
    .reg_req_o  (reg_req    ),
    .loc_bus_o  (loc_bus    ),
    .mem_resp_i (mem_resp   ),
    .rom_resp_i (rom_resp   ),
    .reg_resp_i (reg_resp   )
  );

  // Runs for as long as the external request is up
  ext_timeout_timer ext_timeout_timer_inst (
    .clk_i    (clk_i    ),
    .rst_n_i  (rst_n_i  ),
    .run_i    (ext_req_o),
    .timeout_o(timeout  )
  );

  l2_mem l2_mem_inst (
    .clk_i  (clk_i   ),
    .rst_n_i(rst_n_i ),
    .req_i  (mem_req ),
    .bus_i  (loc_bus ),
    .resp_o (mem_resp)
  );

  boot_rom boot_rom_inst (
    .clk_i  (clk_i   ),
    .rst_n_i(rst_n_i ),
    .req_i  (rom_req ),
    .bus_i  (loc_bus ),
    .resp_o (rom_resp)
  );

  ctrl_regs ctrl_regs_inst (
    .clk_i      (clk_i      ),
    .rst_n_i    (rst_n_i    ),
    .req_i      (reg_req    ),
    .bus_i      (loc_bus    ),
    .resp_o     (reg_resp   ),
    .wake_up_o  (wake_up_o  ), // Cluster is absent, pulses leave the chip
    .eoc_o      (eoc_o      ),
    .eoc_valid_o(eoc_valid_o)
  );

endmodule : msys_top

// File: sim/tb_msys.sv
// System shell testbench
// Directed tests of L2, boot ROM, control registers and the external port,
// driven through the four-phase host port with an external slave model
`timescale 1ns/1ps

module tb_msys;

  import msys_pkg::*;

  localparam int unsigned MaxCycles = 3000;
  localparam data_t       FillMix   = 32'h3C5A_A5C3;

  logic                clk_i;
  logic                rst_n_i;
  logic                req_i;
  bus_req_t            host_req_i;
  logic                ack_o;
  bus_resp_t           host_resp_o;
  logic                busy_o;
  logic                ext_req_o;
  bus_req_t            ext_bus_o;
  logic                ext_ack_i;
  bus_resp_t           ext_resp_i;
  logic [NumCores-1:0] wake_up_o;
  data_t               eoc_o;
  logic                eoc_valid_o;

  logic [15:0]         lfsr_q = 16'd34670;
  int unsigned         last_lat;                // Edges from request to ack
  int unsigned         ext_delay = 1;
  logic                ext_never_ack = 1'b0;
  bus_req_t            ext_seen;                // Last request the slave acked
  data_t               ext_mem [64];
  addr_t               ext_tag [64];
  logic                ext_vld [64];
  int unsigned         wake_pulses = 0;
  logic [NumCores-1:0] wake_mask_seen = '0;

  msys_top msys_top_inst (
    .clk_i      (clk_i      ),
    .rst_n_i    (rst_n_i    ),
    .req_i      (req_i      ),
    .host_req_i (host_req_i ),
    .ack_o      (ack_o      ),
    .host_resp_o(host_resp_o),
    .busy_o     (busy_o     ),
    .ext_req_o  (ext_req_o  ),
    .ext_bus_o  (ext_bus_o  ),
    .ext_ack_i  (ext_ack_i  ),
    .ext_resp_i (ext_resp_i ),
    .wake_up_o  (wake_up_o  ),
    .eoc_o      (eoc_o      ),
    .eoc_valid_o(eoc_valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Cycle budget for the whole run
  initial begin : watchdog
    int unsigned cycles;
    cycles = 0;
    while (cycles < MaxCycles) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", MaxCycles);
    $display("sim failed");
    $fatal(1, "watchdog expired");
  end

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string msg);
    if (actual !== expected) begin
      $display("MISMATCH at %0t ns: %s (got %h, expected %h)", $time, msg, actual,
               expected);
      $display("sim failed");
      $fatal(1, "stopping on first mismatch");
    end
  endtask

  // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] value;
    logic        fb;
    value = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      value  = {value[30:0], fb};
    end
    return value;
  endfunction

  function automatic data_t merge_bytes(data_t old_w, data_t new_w, be_t be);
    data_t mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  // Contents of never-written external words
  function automatic data_t fill_word(addr_t addr);
    return {addr[15:0], addr[31:16]} ^ FillMix;
  endfunction

  function automatic data_t ext_word(addr_t addr);
    if (ext_vld[addr[7:2]] && ext_tag[addr[7:2]] == addr) return ext_mem[addr[7:2]];
    return fill_word(addr);
  endfunction

  // External slave that acks ext_delay cycles after the request shows up
  initial begin : ext_slave
    int unsigned waited;
    waited     = 0;
    ext_ack_i  = 1'b0;
    ext_resp_i = '0;
    for (int i = 0; i < 64; i++) ext_vld[i] = 1'b0;
    forever begin
      @(posedge clk_i);
      #1;
      if (ext_req_o && !ext_ack_i) begin
        waited++;
        if (!ext_never_ack && waited >= ext_delay) begin
          ext_seen         = ext_bus_o;
          ext_resp_i.err   = 1'b0;
          ext_resp_i.rdata = ext_word(ext_bus_o.addr.raw);
          if (ext_bus_o.we) begin
            ext_mem[ext_bus_o.addr.raw[7:2]] =
              merge_bytes(ext_word(ext_bus_o.addr.raw), ext_bus_o.wdata, ext_bus_o.be);
            ext_tag[ext_bus_o.addr.raw[7:2]] = ext_bus_o.addr.raw;
            ext_vld[ext_bus_o.addr.raw[7:2]] = 1'b1;
          end
          ext_ack_i = 1'b1;
        end
      end else if (!ext_req_o) begin
        waited    = 0;
        ext_ack_i = 1'b0;                       // Four-phase release
      end
    end
  end

  always @(posedge clk_i) begin
    #1;
    if (wake_up_o != '0) begin
      wake_pulses++;
      wake_mask_seen = wake_up_o;
    end
  end

  // One four-phase host transaction with a random hold after ack
  task automatic host_access(input addr_t addr, input data_t wdata, input be_t be,
                             input logic we, output bus_resp_t resp);
    int unsigned hold;
    hold = rand_bits(3);
    check(busy_o, 1'b0, "busy_o low before request");
    host_req_i.addr.raw = addr;
    host_req_i.wdata    = wdata;
    host_req_i.be       = be;
    host_req_i.we       = we;
    req_i               = 1'b1;
    last_lat            = 0;
    do begin
      @(posedge clk_i);
      #1;
      last_lat++;
      check(busy_o, 1'b1, "busy_o high while request is open");
    end while (!ack_o);
    resp = host_resp_o;
    check(ext_req_o, 1'b0, "ext_req_o low once ack_o is up");
    repeat (hold) begin
      @(posedge clk_i);
      #1;
      check(ack_o, 1'b1, "ack_o held while req_i is high");
      check(host_resp_o.rdata, resp.rdata, "rdata stable during hold");
      check(host_resp_o.err, resp.err, "err stable during hold");
    end
    req_i = 1'b0;
    @(posedge clk_i);
    #1;
    check(ack_o, 1'b0, "ack_o falls after req_i");
    check(busy_o, 1'b0, "busy_o low after ack_o falls");
  endtask

  task automatic l2_readback();
    data_t      shadow [L2NumWords];
    logic [7:0] slot [8];
    bus_resp_t  resp;
    data_t      wdata;
    be_t        be;
    addr_t      addr;
    for (int s = 0; s < 8; s++) begin
      slot[s] = 8'(rand_bits(8));
      addr    = L2BaseAddr + {22'd0, slot[s], 2'b00};
      wdata   = rand_bits(32);
      host_access(addr, wdata, 4'hF, 1'b1, resp);
      check(last_lat, 3, "L2 access latency");
      shadow[slot[s]] = wdata;
      repeat (2) begin
        wdata = rand_bits(32);
        be    = be_t'(rand_bits(4));
        host_access(addr, wdata, be, 1'b1, resp);
        check(resp.rdata, shadow[slot[s]], "L2 write returns old word");
        shadow[slot[s]] = merge_bytes(shadow[slot[s]], wdata, be);
      end
    end
    for (int s = 0; s < 8; s++) begin
      host_access(L2BaseAddr + {22'd0, slot[s], 2'b00}, '0, 4'hF, 1'b0, resp);
      check(resp.rdata, shadow[slot[s]], "L2 read-back");
      check(resp.err, 1'b0, "L2 read err");
    end
  endtask

  task automatic boot_rom_reads();
    bus_resp_t resp;
    for (int i = 0; i < 16; i++) begin
      host_access(BootBaseAddr + addr_t'(4 * i), '0, 4'hF, 1'b0, resp);
      check(resp.rdata, 32'hB007_0000 + i, "boot ROM word");
      check(resp.err, 1'b0, "boot ROM read err");
      check(last_lat, 3, "boot ROM latency");
    end
    host_access(BootBaseAddr + 32'd80, '0, 4'hF, 1'b0, resp);
    check(resp.rdata, '0, "boot ROM word past table end");
    host_access(BootBaseAddr + 32'd4, 32'h1234_5678, 4'hF, 1'b1, resp);
    check(resp.err, 1'b1, "boot ROM write err");
    check(resp.rdata, ErrData, "boot ROM write data");
  endtask

  task automatic ctrl_reg_access();
    bus_resp_t           resp;
    logic [NumCores-1:0] mask;
    data_t               eoc;
    repeat (2) begin
      mask = NumCores'(rand_bits(NumCores));
      if (mask == '0) mask = 4'b1001;
      wake_pulses = 0;
      host_access(CtrlBaseAddr, {28'd0, mask}, 4'hF, 1'b1, resp);
      check(resp.err, 1'b0, "wake-up write err");
      check(wake_pulses, 1, "wake-up pulse length");
      check(wake_mask_seen, mask, "wake-up mask");
    end
    eoc = rand_bits(32) | 32'd1;
    host_access(CtrlBaseAddr + 32'h4, eoc, 4'hF, 1'b1, resp);
    check(eoc_valid_o, 1'b1, "eoc_valid_o after eoc write");
    check(eoc_o, eoc, "eoc_o value");
    host_access(CtrlBaseAddr + 32'h4, '0, 4'hF, 1'b0, resp);
    check(resp.rdata, eoc, "eoc read-back");
    // Clear the low byte only
    host_access(CtrlBaseAddr + 32'h4, '0, 4'b0001, 1'b1, resp);
    eoc = merge_bytes(eoc, '0, 4'b0001);
    check(eoc_valid_o, 1'b0, "eoc_valid_o after clear");
    host_access(CtrlBaseAddr + 32'h4, '0, 4'hF, 1'b0, resp);
    check(resp.rdata, eoc, "eoc byte-enable read-back");
    host_access(CtrlBaseAddr + 32'h8, '0, 4'hF, 1'b0, resp);
    check(resp.rdata, TcdmStartAddr, "TCDM start constant");
    host_access(CtrlBaseAddr + 32'hC, '0, 4'hF, 1'b0, resp);
    check(resp.rdata, 32'd4, "core count constant");
    check(resp.err, 1'b0, "core count read err");
    host_access(CtrlBaseAddr + 32'hC, 32'd7, 4'hF, 1'b1, resp);
    check(resp.err, 1'b1, "write to read-only register");
    host_access(CtrlBaseAddr + 32'h10, '0, 4'hF, 1'b0, resp);
    check(resp.err, 1'b1, "undefined offset err");
    check(resp.rdata, ErrData, "undefined offset data");
  endtask

  task automatic ext_write_read(input addr_t addr);
    bus_resp_t resp;
    data_t     wdata;
    data_t     expected;
    be_t       be;
    wdata    = rand_bits(32);
    be       = be_t'(rand_bits(4));
    expected = merge_bytes(ext_word(addr), wdata, be);
    host_access(addr, wdata, be, 1'b1, resp);
    check(resp.err, 1'b0, "external write err");
    check(ext_seen.addr.raw, addr, "external write address");
    check(ext_seen.wdata, wdata, "external write data");
    check(ext_seen.be, be, "external write byte enables");
    check(ext_seen.we, 1'b1, "external write flag");
    host_access(addr, '0, 4'hF, 1'b0, resp);
    check(resp.rdata, expected, "external read data");
    check(ext_seen.addr.raw, addr, "external read address");
    check(ext_seen.we, 1'b0, "external read flag");
  endtask

  task automatic external_passthrough();
    logic [15:0] region;
    logic [13:0] offs;
    for (int d = 1; d <= 10; d++) begin
      ext_delay = d;
      region    = 16'(rand_bits(16));
      offs      = 14'(rand_bits(14));
      if (region == 16'h4000 || region == 16'h8000 || region == 16'hA000) begin
        region ^= 16'h0100;                     // Keep it outside the map
      end
      ext_write_read({region, offs, 2'b00});
    end
    ext_delay = 3;
    ext_write_read(32'h8000_1000);              // L2 region past its 1 KiB
    ext_write_read(32'h4001_0010);
  endtask

  task automatic timeout_recovery();
    bus_resp_t resp;
    ext_never_ack = 1'b1;
    host_access(32'h1234_5678, '0, 4'hF, 1'b0, resp);
    check(resp.err, 1'b1, "timeout read err");
    check(resp.rdata, ErrData, "timeout read data");
    check(last_lat > ExtTimeoutCycles, 1'b1, "timeout waited long enough");
    host_access(32'h1234_5678, 32'hFFFF_0000, 4'hF, 1'b1, resp);
    check(resp.err, 1'b1, "timeout write err");
    ext_never_ack = 1'b0;
    ext_delay     = 2;
    host_access(32'h1234_5678, '0, 4'hF, 1'b0, resp);
    check(resp.err, 1'b0, "external access after timeout");
    check(resp.rdata, fill_word(32'h1234_5678), "unwritten external word");
  endtask

  initial begin
    rst_n_i    = 1'b0;
    req_i      = 1'b0;
    host_req_i = '0;
    repeat (4) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    check(ack_o, 1'b0, "ack_o after reset");
    check(ext_req_o, 1'b0, "ext_req_o after reset");
    check(busy_o, 1'b0, "busy_o after reset");
    check(wake_up_o, '0, "wake_up_o after reset");
    check(eoc_valid_o, 1'b0, "eoc_valid_o after reset");
    l2_readback();
    boot_rom_reads();
    ctrl_reg_access();
    external_passthrough();
    timeout_recovery();
    $display("sim passed");
    $finish;
  end

endmodule : tb_msys

// File: verilog.f
design/msys_pkg.sv
design/bus_router.sv
design/ext_timeout_timer.sv
design/l2_mem.sv
design/boot_rom.sv
design/ctrl_regs.sv
design/msys_top.sv
sim/tb_msys.sv
